//--- tcdm_group_pkg.sv
// -----------------------------------------------
// TCDM group shared definitions
// Sizes, address fields and request/response types
// -----------------------------------------------

`default_nettype none

package tcdm_group_pkg;

  // -----------------------------------------------
  // Sizes
  // -----------------------------------------------

  // Tile ports and banks come in equal numbers
  localparam int unsigned NUM_TILES = 4;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned BE_W      = DATA_W / 8;
  localparam int unsigned ROWS      = 16;

  localparam int unsigned ROW_W  = $clog2(ROWS);
  localparam int unsigned TILE_W = $clog2(NUM_TILES);

  // Bank index in the low bits, row in the high bits
  localparam int unsigned ADDR_W = ROW_W + TILE_W;

  // -----------------------------------------------
  // Request and response types
  // -----------------------------------------------

  // Word request as issued by a tile
  typedef struct packed {
    logic [ADDR_W-1:0] tgt_addr;
    logic              wen;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } tcdm_req_t;

  // Request after bank decode, tagged with its initiator
  typedef struct packed {
    logic [ROW_W-1:0]  row;
    logic [TILE_W-1:0] ini_addr;
    logic              wen;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } bank_req_t;

  // Bank response routed back by initiator index
  typedef struct packed {
    logic [TILE_W-1:0] ini_addr;
    logic [DATA_W-1:0] rdata;
  } bank_resp_t;

endpackage

`default_nettype wire

//--- tcdm_spill_reg.sv
// -----------------------------------------------
// Request spill register
// Two-slot cut on the valid/ready path of one port
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tcdm_spill_reg (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  tcdm_group_pkg::tcdm_req_t data_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output tcdm_group_pkg::tcdm_req_t data_o,
  output logic                      valid_o,
  input  logic                      ready_i
);
  import tcdm_group_pkg::*;

  tcdm_req_t a_data_q;
  tcdm_req_t b_data_q;
  logic      a_full_q;
  logic      b_full_q;
  logic      a_fill;
  logic      a_drain;
  logic      b_fill;
  logic      b_drain;

  // Slot a takes input, slot b holds the older entry on a stall
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Older slot first
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign valid_o = a_full_q || b_full_q;
  assign ready_o = !a_full_q || !b_full_q;

endmodule

`default_nettype wire

//--- tcdm_arbiter.sv
// -----------------------------------------------
// TCDM bank arbiter
// Bank decode, round-robin grants, outstanding flags
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tcdm_arbiter (
  input  logic                                                              clk_i,
  input  logic                                                              rst_n_i,
  input  tcdm_group_pkg::tcdm_req_t [tcdm_group_pkg::NUM_TILES-1:0]         req_i,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                              req_valid_i,
  output logic [tcdm_group_pkg::NUM_TILES-1:0]                              req_ready_o,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                              bank_ready_i,
  output logic [tcdm_group_pkg::NUM_TILES-1:0][tcdm_group_pkg::NUM_TILES-1:0] bank_gnt_o,
  output tcdm_group_pkg::bank_req_t [tcdm_group_pkg::NUM_TILES-1:0]         bank_req_o,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                              resp_done_i
);
  import tcdm_group_pkg::*;

  logic [NUM_TILES-1:0]                 outst_q;
  logic [NUM_TILES-1:0]                 eligible;
  logic [NUM_TILES-1:0][NUM_TILES-1:0]  contend;
  logic [NUM_TILES-1:0][TILE_W-1:0]     ptr_q;
  logic [NUM_TILES-1:0][TILE_W-1:0]     win;

  // One request in flight per port past the cut
  assign eligible = req_valid_i & ~outst_q;

  // Contenders per bank from the interleaved index bits
  always_comb begin
    contend = '0;
    for (int b = 0; b < NUM_TILES; b++) begin
      for (int p = 0; p < NUM_TILES; p++) begin
        contend[b][p] = eligible[p] && (req_i[p].tgt_addr[TILE_W-1:0] == TILE_W'(b));
      end
    end
  end

  // -----------------------------------------------
  // Round-robin grant per bank
  // -----------------------------------------------

  always_comb begin
    logic [TILE_W-1:0] idx;
    logic              found;
    idx        = '0;
    bank_gnt_o = '0;
    win        = '0;
    for (int b = 0; b < NUM_TILES; b++) begin
      found = 1'b0;
      for (int i = 0; i < NUM_TILES; i++) begin
        idx = ptr_q[b] + TILE_W'(i);
        if (!found && bank_ready_i[b] && contend[b][idx]) begin
          found            = 1'b1;
          bank_gnt_o[b][idx] = 1'b1;
          win[b]           = idx;
        end
      end
    end
  end

  // A port is taken when any bank grants it
  always_comb begin
    req_ready_o = '0;
    for (int b = 0; b < NUM_TILES; b++) begin
      req_ready_o = req_ready_o | bank_gnt_o[b];
    end
  end

  always_comb begin
    for (int b = 0; b < NUM_TILES; b++) begin
      bank_req_o[b].row      = req_i[win[b]].tgt_addr[ADDR_W-1:TILE_W];
      bank_req_o[b].ini_addr = win[b];
      bank_req_o[b].wen      = req_i[win[b]].wen;
      bank_req_o[b].wdata    = req_i[win[b]].wdata;
      bank_req_o[b].be       = req_i[win[b]].be;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q   <= '0;
      outst_q <= '0;
    end else begin
      for (int b = 0; b < NUM_TILES; b++) begin
        if (|bank_gnt_o[b]) begin
          ptr_q[b] <= win[b] + TILE_W'(1);
        end
      end
      outst_q <= (outst_q & ~resp_done_i) | req_ready_o;
    end
  end

endmodule

`default_nettype wire

//--- tcdm_bank.sv
// -----------------------------------------------
// TCDM memory bank
// Byte-enable storage with a held response register
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tcdm_bank (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0] gnt_i,
  input  tcdm_group_pkg::bank_req_t            req_i,
  output logic                                 ready_o,
  output tcdm_group_pkg::bank_resp_t           resp_o,
  output logic                                 resp_valid_o,
  input  logic                                 resp_ready_i
);
  import tcdm_group_pkg::*;

  logic [DATA_W-1:0] mem_q [ROWS];
  logic [DATA_W-1:0] row_data;
  logic [DATA_W-1:0] merged;
  logic              access;
  bank_resp_t        resp_q;
  logic              resp_valid_q;

  // Any granted port means an access this cycle
  assign access = |gnt_i;

  // Free when empty or the held response leaves now
  assign ready_o = !resp_valid_q || resp_ready_i;

  // -----------------------------------------------
  // Byte merge
  // -----------------------------------------------

  always_comb begin
    row_data = mem_q[req_i.row];
    merged   = row_data;
    for (int k = 0; k < BE_W; k++) begin
      if (req_i.be[k]) begin
        merged[8*k +: 8] = req_i.wdata[8*k +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_q        <= '{default: '0};
      resp_valid_q <= 1'b0;
    end else begin
      if (access && req_i.wen) begin
        mem_q[req_i.row] <= merged;
      end
      if (access) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready_i) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  // Write returns the row after the merge
  always_ff @(posedge clk_i) begin
    if (access) begin
      resp_q.ini_addr <= req_i.ini_addr;
      resp_q.rdata    <= req_i.wen ? merged : row_data;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

endmodule

`default_nettype wire

//--- tcdm_resp_router.sv
// -----------------------------------------------
// TCDM response router
// Bank responses back to ports, lowest bank first
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tcdm_resp_router (
  input  tcdm_group_pkg::bank_resp_t [tcdm_group_pkg::NUM_TILES-1:0]        bank_resp_i,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                             bank_valid_i,
  output logic [tcdm_group_pkg::NUM_TILES-1:0]                             bank_ready_o,
  output logic [tcdm_group_pkg::NUM_TILES-1:0][tcdm_group_pkg::DATA_W-1:0] resp_rdata_o,
  output logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_valid_o,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_ready_i,
  output logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_done_o
);
  import tcdm_group_pkg::*;

  // -----------------------------------------------
  // Per-port selection
  // -----------------------------------------------

  always_comb begin
    logic found;
    found        = 1'b0;
    bank_ready_o = '0;
    resp_valid_o = '0;
    resp_rdata_o = '0;
    for (int p = 0; p < NUM_TILES; p++) begin
      found = 1'b0;
      for (int b = 0; b < NUM_TILES; b++) begin
        if (!found && bank_valid_i[b] && (bank_resp_i[b].ini_addr == TILE_W'(p))) begin
          found           = 1'b1;
          resp_valid_o[p] = 1'b1;
          resp_rdata_o[p] = bank_resp_i[b].rdata;
          // Losing banks keep ready low
          bank_ready_o[b] = resp_ready_i[p];
        end
      end
    end
  end

  // Completed handshake frees the port at the arbiter
  assign resp_done_o = resp_valid_o & resp_ready_i;

endmodule

`default_nettype wire

//--- tcdm_group.sv
// -----------------------------------------------
// TCDM group local interconnect
// Four tile ports onto four interleaved banks
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tcdm_group (
  input  logic                                                             clk_i,
  input  logic                                                             rst_n_i,
  input  tcdm_group_pkg::tcdm_req_t [tcdm_group_pkg::NUM_TILES-1:0]         req_i,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                             req_valid_i,
  output logic [tcdm_group_pkg::NUM_TILES-1:0]                             req_ready_o,
  output logic [tcdm_group_pkg::NUM_TILES-1:0][tcdm_group_pkg::DATA_W-1:0] resp_rdata_o,
  output logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_valid_o,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_ready_i
);
  import tcdm_group_pkg::*;

  tcdm_req_t  [NUM_TILES-1:0]                cut_req;
  logic       [NUM_TILES-1:0]                cut_valid;
  logic       [NUM_TILES-1:0]                cut_ready;
  logic       [NUM_TILES-1:0][NUM_TILES-1:0] bank_gnt;
  bank_req_t  [NUM_TILES-1:0]                bank_req;
  logic       [NUM_TILES-1:0]                bank_ready;
  bank_resp_t [NUM_TILES-1:0]                bank_resp;
  logic       [NUM_TILES-1:0]                bank_resp_valid;
  logic       [NUM_TILES-1:0]                bank_resp_ready;
  logic       [NUM_TILES-1:0]                resp_done;

  // Request cut per port
  for (genvar p = 0; p < NUM_TILES; p++) begin : gen_ports
    tcdm_spill_reg spill_reg_inst (
      .clk_i  (clk_i         ),
      .rst_n_i(rst_n_i       ),
      .data_i (req_i[p]      ),
      .valid_i(req_valid_i[p]),
      .ready_o(req_ready_o[p]),
      .data_o (cut_req[p]    ),
      .valid_o(cut_valid[p]  ),
      .ready_i(cut_ready[p]  )
    );
  end

  tcdm_arbiter arbiter_inst (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .req_i       (cut_req   ),
    .req_valid_i (cut_valid ),
    .req_ready_o (cut_ready ),
    .bank_ready_i(bank_ready),
    .bank_gnt_o  (bank_gnt  ),
    .bank_req_o  (bank_req  ),
    .resp_done_i (resp_done )
  );

  for (genvar b = 0; b < NUM_TILES; b++) begin : gen_banks
    tcdm_bank bank_inst (
      .clk_i       (clk_i             ),
      .rst_n_i     (rst_n_i           ),
      .gnt_i       (bank_gnt[b]       ),
      .req_i       (bank_req[b]       ),
      .ready_o     (bank_ready[b]     ),
      .resp_o      (bank_resp[b]      ),
      .resp_valid_o(bank_resp_valid[b]),
      .resp_ready_i(bank_resp_ready[b])
    );
  end

  tcdm_resp_router resp_router_inst (
    .bank_resp_i (bank_resp      ),
    .bank_valid_i(bank_resp_valid),
    .bank_ready_o(bank_resp_ready),
    .resp_rdata_o(resp_rdata_o   ),
    .resp_valid_o(resp_valid_o   ),
    .resp_ready_i(resp_ready_i   ),
    .resp_done_o (resp_done      )
  );

endmodule

`default_nettype wire

//--- tcdm_group_checker.sv
// -----------------------------------------------
// TCDM group response checker
// Memory model per port and in-order response compare
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tcdm_group_checker (
  input  logic                                                             clk_i,
  input  logic                                                             rst_n_i,
  input  tcdm_group_pkg::tcdm_req_t [tcdm_group_pkg::NUM_TILES-1:0]         req_i,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                             req_valid_i,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                             req_ready_o,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0][tcdm_group_pkg::DATA_W-1:0] resp_rdata_o,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_valid_o,
  input  logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_ready_i,
  output int                                                               errors_o,
  output int                                                               accepted_o,
  output int                                                               responses_o
);
  import tcdm_group_pkg::*;

  logic [DATA_W-1:0] model [2**ADDR_W];
  logic [DATA_W-1:0] expect_q [NUM_TILES][$];
  int                index_q [NUM_TILES][$];
  int                accepts [NUM_TILES];
  logic              first_cycle = 1'b1;
  int                errors = 0;
  int                accepted = 0;
  int                responses = 0;

  // Phase of a request from its per-port index
  function automatic string test_name(input int n);
    if (n < 8) return "read_before_write";
    if (n < 40) return "write_then_read";
    if (n < 80) return "bank_contention";
    return "random_traffic";
  endfunction

  // Enabled bytes replace the old word
  function automatic logic [DATA_W-1:0] apply_write(input logic [DATA_W-1:0] old,
                                                    input logic [DATA_W-1:0] wdata,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] word;
    word = old;
    for (int k = 0; k < BE_W; k++) begin
      if (be[k]) word[8*k +: 8] = wdata[8*k +: 8];
    end
    return word;
  endfunction

  initial begin
    for (int a = 0; a < 2**ADDR_W; a++) model[a] = '0;
    for (int p = 0; p < NUM_TILES; p++) accepts[p] = 0;
  end

  always @(posedge clk_i) begin
    logic [DATA_W-1:0] word;
    int                n;
    if (!rst_n_i) begin
      first_cycle = 1'b1;
    end else begin
      if (first_cycle) begin
        if (resp_valid_o !== {NUM_TILES{1'b0}}) begin
          $display("[ERROR] reset_state resp_valid_o: expected %h, actual %h",
                   {NUM_TILES{1'b0}}, resp_valid_o);
          errors++;
        end
        if (req_ready_o !== {NUM_TILES{1'b1}}) begin
          $display("[ERROR] reset_state req_ready_o: expected %h, actual %h",
                   {NUM_TILES{1'b1}}, req_ready_o);
          errors++;
        end
        first_cycle = 1'b0;
      end
      for (int p = 0; p < NUM_TILES; p++) begin
        if (req_valid_i[p] && req_ready_o[p]) begin
          word = model[req_i[p].tgt_addr];
          if (req_i[p].wen) word = apply_write(word, req_i[p].wdata, req_i[p].be);
          model[req_i[p].tgt_addr] = word;
          expect_q[p].push_back(word);
          index_q[p].push_back(accepts[p]);
          accepts[p]++;
          accepted++;
        end
        if (resp_valid_o[p] && resp_ready_i[p]) begin
          responses++;
          if (expect_q[p].size() == 0) begin
            $display("Port %0d returned a response with no request waiting", p);
            errors++;
          end else begin
            word = expect_q[p].pop_front();
            n    = index_q[p].pop_front();
            if (resp_rdata_o[p] !== word) begin
              $display("[ERROR] %s port %0d request %0d: expected %h, actual %h",
                       test_name(n), p, n, word, resp_rdata_o[p]);
              errors++;
            end
          end
        end
      end
    end
  end

  assign errors_o    = errors;
  assign accepted_o  = accepted;
  assign responses_o = responses;

endmodule

`default_nettype wire

//--- tcdm_group_assert.sv
// -----------------------------------------------
// TCDM group port assertions
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tcdm_group_assert (
  input logic                                                             clk_i,
  input logic                                                             rst_n_i,
  input tcdm_group_pkg::tcdm_req_t [tcdm_group_pkg::NUM_TILES-1:0]         req_i,
  input logic [tcdm_group_pkg::NUM_TILES-1:0]                             req_valid_i,
  input logic [tcdm_group_pkg::NUM_TILES-1:0]                             req_ready_o,
  input logic [tcdm_group_pkg::NUM_TILES-1:0][tcdm_group_pkg::DATA_W-1:0] resp_rdata_o,
  input logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_valid_o,
  input logic [tcdm_group_pkg::NUM_TILES-1:0]                             resp_ready_i
);
  import tcdm_group_pkg::*;

  int fail_count = 0;

  for (genvar p = 0; p < NUM_TILES; p++) begin : gen_ports
    resp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_valid_o[p] && !resp_ready_i[p] |=> resp_valid_o[p] && $stable(resp_rdata_o[p]))
      else begin
        fail_count++;
        $error("Response on port %0d changed before it was taken", p);
      end
    req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i[p] && !req_ready_o[p] |=> req_valid_i[p] && $stable(req_i[p]))
      else begin
        fail_count++;
        $error("Request on port %0d changed before it was accepted", p);
      end
  end

  // Nothing comes back while in reset
  quiet_reset: assert property (@(posedge clk_i) !rst_n_i |=> resp_valid_o == '0)
    else begin
      fail_count++;
      $error("Response valid seen during reset");
    end

endmodule

bind tcdm_group tcdm_group_assert assert_inst (.*);

`default_nettype wire

//--- tb_tcdm_group.sv
// -----------------------------------------------
// TCDM group testbench
// Seeded random traffic on all four tile ports
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_tcdm_group;
  import tcdm_group_pkg::*;

  localparam int REQS_PER_PORT  = 200;
  localparam int TOTAL_REQS     = NUM_TILES * REQS_PER_PORT;
  // About 25 cycles per request across all ports
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * 25;

  logic                                 clk_i;
  logic                                 rst_n_i;
  tcdm_req_t [NUM_TILES-1:0]            req_i;
  logic [NUM_TILES-1:0]                 req_valid_i;
  logic [NUM_TILES-1:0]                 req_ready_o;
  logic [NUM_TILES-1:0][DATA_W-1:0]     resp_rdata_o;
  logic [NUM_TILES-1:0]                 resp_valid_o;
  logic [NUM_TILES-1:0]                 resp_ready_i;
  integer                               seed = 32'hc408;
  int                                   issued [NUM_TILES] = '{default: 0};
  logic [ADDR_W-1:0]                    pair_addr [NUM_TILES];
  int                                   cycle_count = 0;
  int                                   errors;
  int                                   accepted;
  int                                   responses;
  int                                   assert_fails;

  tcdm_group tcdm_group_inst (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_i       (req_i       ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .resp_rdata_o(resp_rdata_o),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i)
  );

  tcdm_group_checker checker_inst (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .req_i       (req_i       ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .resp_rdata_o(resp_rdata_o),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .errors_o    (errors      ),
    .accepted_o  (accepted    ),
    .responses_o (responses   )
  );

  always #50 clk_i = ~clk_i;

  // Rows carry the port index in their top bits
  function automatic tcdm_req_t next_req(input int port, input int n);
    tcdm_req_t         r;
    logic [TILE_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    bank = (n >= 40 && n < 80) ? '0 : TILE_W'($random(seed));
    row  = ROW_W'($random(seed));
    row[ROW_W-1 -: TILE_W] = TILE_W'(port);
    r.tgt_addr = {row, bank};
    r.wen      = (n < 8) ? 1'b0 : 1'($random(seed));
    r.wdata    = DATA_W'($random(seed));
    r.be       = BE_W'($random(seed));
    if (n >= 8 && n < 40) begin
      if (n % 2 == 0) begin
        r.wen          = 1'b1;
        r.be           = '1;
        pair_addr[port] = r.tgt_addr;
      end else begin
        r.wen      = 1'b0;
        r.tgt_addr = pair_addr[port];
      end
    end
    return r;
  endfunction

  always @(posedge clk_i) begin
    if (rst_n_i) begin
      for (int p = 0; p < NUM_TILES; p++) begin
        resp_ready_i[p] <= (issued[p] < 40) ? 1'b1 : (($random(seed) & 3) != 0);
        if (!req_valid_i[p] || req_ready_o[p]) begin
          if (issued[p] < REQS_PER_PORT &&
              ((issued[p] >= 40 && issued[p] < 80) || ($random(seed) & 3) != 0)) begin
            req_i[p]       <= next_req(p, issued[p]);
            req_valid_i[p] <= 1'b1;
            issued[p]      <= issued[p] + 1;
          end else begin
            req_valid_i[p] <= 1'b0;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: %0d of %0d responses after %0d cycles", responses, TOTAL_REQS,
               cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    req_i        = '0;
    req_valid_i  = '0;
    resp_ready_i = '1;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    while (accepted < TOTAL_REQS || responses < TOTAL_REQS) @(posedge clk_i);
    // Let any stray extra response show up
    repeat (4) @(posedge clk_i);
    assert_fails = tcdm_group_inst.assert_inst.fail_count;
    if (responses != accepted) begin
      $display("Response count %0d does not match accepted requests %0d", responses, accepted);
    end
    $display("Errors: %0d compare, %0d assertion; %0d responses for %0d requests",
             errors, assert_fails, responses, accepted);
    if (errors == 0 && assert_fails == 0 && responses == TOTAL_REQS && accepted == TOTAL_REQS)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tcdm_group.f
tcdm_group_pkg.sv
tcdm_spill_reg.sv
tcdm_arbiter.sv
tcdm_bank.sv
tcdm_resp_router.sv
tcdm_group.sv
tcdm_group_checker.sv
tcdm_group_assert.sv
tb_tcdm_group.sv
